// File: common/msx_pkg.sv
package msx_pkg;

   // CPU bus widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 8;

   // Audio and input widths
   localparam int AUDIO_W     = 16;
   localparam int PSG_LEVEL_W = 10;
   localparam int JOY_W       = 6;

   // Upper five I/O address bits of each chip's port group
   localparam logic [4:0] VDP_PORT_BASE = 5'b10011;  // 98h-9Fh
   localparam logic [4:0] PSG_PORT_BASE = 5'b10100;  // A0h-A3h
   localparam logic [4:0] PPI_PORT_BASE = 5'b10101;  // A8h-ABh

   // PSG I/O port registers
   localparam logic [3:0] PSG_REG_PORTA = 4'd14;
   localparam logic [3:0] PSG_REG_PORTB = 4'd15;

   // Mixer weights, in PSG level units
   localparam int BEEP_WEIGHT = 512;
   localparam int CAS_WEIGHT  = 256;

   // PPI port A, seen by the CPU as a byte and by the memory side
   // as four primary slot numbers, one per 16 KB page
   typedef union packed {
      logic [DATA_W-1:0] raw;
      logic [3:0][1:0]   slot;
   } slot_reg_u;

   // Source of CPU read data
   typedef enum logic [1:0] {
      SEL_NONE,
      SEL_VDP,
      SEL_PSG,
      SEL_PPI
   } io_sel_e;

endpackage

// File: common/cpu_bus_if.sv
`timescale 1ns/1ps

interface cpu_bus_if;
   import msx_pkg::*;

   logic [1:0]        addr;
   logic [DATA_W-1:0] wdata;
   logic              rd;
   logic              wr;
   logic              req;     // One clk21m cycle at access start
   logic              ppi_cs;
   logic              psg_cs;

   modport decoder (
      output addr, wdata, rd, wr, req, ppi_cs, psg_cs
   );

   modport ppi (
      input addr, wdata, rd, wr, req, ppi_cs, psg_cs
   );

   modport psg (
      input addr, wdata, rd, wr, req, ppi_cs, psg_cs
   );

endinterface

// File: design/io_select.sv
`timescale 1ns/1ps

module io_select (
   input  logic                        clk21m,
   input  logic                        exwait_n,
   input  logic [msx_pkg::ADDR_W-1:0]  addr_i,
   input  logic [msx_pkg::DATA_W-1:0]  data_i,
   input  logic                        iorq_n_i,
   input  logic                        mreq_n_i,
   input  logic                        rd_n_i,
   input  logic                        wr_n_i,
   input  logic                        m1_n_i,
   input  logic [msx_pkg::DATA_W-1:0]  ppi_rdata_i,
   input  logic [msx_pkg::DATA_W-1:0]  psg_rdata_i,
   input  logic [msx_pkg::DATA_W-1:0]  vdp_data_i,
   output logic                        vdp_cs_o,
   output logic [msx_pkg::DATA_W-1:0]  data_o,
   cpu_bus_if.decoder                  bus
);
   import msx_pkg::*;

   logic    io_cycle;
   logic    ppi_cs;
   logic    psg_cs;
   logic    req;
   logic    ack_q;
   io_sel_e sel;

   // Interrupt acknowledge also drives iorq, so M1 cycles are excluded
   assign io_cycle = ~iorq_n_i & m1_n_i;
   assign vdp_cs_o = io_cycle && (addr_i[7:3] == VDP_PORT_BASE);
   assign psg_cs   = io_cycle && (addr_i[7:3] == PSG_PORT_BASE);
   assign ppi_cs   = io_cycle && (addr_i[7:3] == PPI_PORT_BASE);

   // Request pulse until acknowledged
   assign req = ~(iorq_n_i & mreq_n_i) & ~(rd_n_i & wr_n_i) & ~ack_q;

   // Ack holds until both iorq and mreq go inactive
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         ack_q <= 1'b0;
      end else if (iorq_n_i && mreq_n_i) begin
         ack_q <= 1'b0;
      end else if (req) begin
         ack_q <= 1'b1;
      end
   end

   assign bus.addr   = addr_i[1:0];
   assign bus.wdata  = data_i;
   assign bus.rd     = ~rd_n_i;
   assign bus.wr     = ~wr_n_i;
   assign bus.req    = req;
   assign bus.ppi_cs = ppi_cs;
   assign bus.psg_cs = psg_cs;

   // VDP first, then PSG, then PPI
   always_comb begin
      if (vdp_cs_o) sel = SEL_VDP;
      else if (psg_cs) sel = SEL_PSG;
      else if (ppi_cs) sel = SEL_PPI;
      else sel = SEL_NONE;
   end

   always_comb begin
      data_o = 8'hFF;
      if (!rd_n_i) begin
         case (sel)
            SEL_VDP: data_o = vdp_data_i;
            SEL_PSG: data_o = psg_rdata_i;
            SEL_PPI: data_o = ppi_rdata_i;
            default: data_o = 8'hFF;
         endcase
      end
   end

   a_one_cs: assert property (@(posedge clk21m) disable iff (!exwait_n)
      $onehot0({vdp_cs_o, psg_cs, ppi_cs}));

endmodule

// File: design/wait_gen.sv
`timescale 1ns/1ps

module wait_gen (
   input  logic clk21m,
   input  logic exwait_n,
   input  logic ce_3m58_p_i,
   input  logic m1_n_i,
   output logic wait_n_o
);

   logic m1_q;
   logic m1_dly_q;

   // Both stages advance on the CPU clock enable only
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         m1_q     <= 1'b0;
         m1_dly_q <= 1'b0;
      end else if (ce_3m58_p_i) begin
         m1_q     <= ~m1_n_i;
         m1_dly_q <= m1_q;
      end
   end

   // Low from the first tick seeing M1 until the delayed copy catches up
   assign wait_n_o = ~(m1_q & ~m1_dly_q);

   // One CPU clock of wait per M1, released by the second tick
   a_wait_len: assert property (@(posedge clk21m) disable iff (!exwait_n)
      $fell(wait_n_o) |-> ce_3m58_p_i [->2] ##0 wait_n_o);

endmodule

// File: design/ppi/ppi_slot_port.sv
`timescale 1ns/1ps

module ppi_slot_port (
   input  logic                        clk21m,
   input  logic                        exwait_n,
   cpu_bus_if.ppi                      bus,
   input  logic [1:0]                  page_i,
   input  logic [msx_pkg::DATA_W-1:0]  kb_data_i,
   output logic [msx_pkg::DATA_W-1:0]  rdata_o,
   output logic [1:0]                  active_slot_o,
   output logic [3:0]                  kb_row_o,
   output logic                        cas_motor_o,
   output logic                        keybeep_o
);
   import msx_pkg::*;

   slot_reg_u         slot_q;
   logic [DATA_W-1:0] port_c_q;
   logic              valid_q;
   logic              wr_en;

   assign wr_en = bus.req & bus.wr & bus.ppi_cs;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         slot_q   <= '0;
         port_c_q <= '0;
      end else if (wr_en) begin
         case (bus.addr)
            2'd0: slot_q.raw <= bus.wdata;
            2'd2: port_c_q <= bus.wdata;
            2'd3: begin
               // Bit set/reset on port C, mode words are ignored
               if (!bus.wdata[7]) begin
                  port_c_q[bus.wdata[3:1]] <= bus.wdata[0];
               end
            end
            default: ;
         endcase
      end
   end

   // Slot map is not trusted until software touched the PPI
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         valid_q <= 1'b0;
      end else if (bus.req && bus.ppi_cs) begin
         valid_q <= 1'b1;
      end
   end

   assign active_slot_o = valid_q ? slot_q.slot[page_i] : 2'b00;

   always_comb begin
      rdata_o = 8'hFF;
      if (bus.rd && bus.ppi_cs) begin
         case (bus.addr)
            2'd0:    rdata_o = slot_q.raw;
            2'd1:    rdata_o = kb_data_i;
            2'd2:    rdata_o = port_c_q;
            default: rdata_o = 8'hFF;
         endcase
      end
   end

   assign kb_row_o    = port_c_q[3:0];
   assign cas_motor_o = port_c_q[4];
   assign keybeep_o   = port_c_q[7];

endmodule

// File: design/psg/psg_port.sv
`timescale 1ns/1ps

module psg_port (
   input  logic                        clk21m,
   input  logic                        exwait_n,
   cpu_bus_if.psg                      bus,
   input  logic [msx_pkg::JOY_W-1:0]   joy0_i,
   input  logic [msx_pkg::JOY_W-1:0]   joy1_i,
   input  logic                        cas_audio_i,
   output logic [msx_pkg::DATA_W-1:0]  rdata_o
);
   import msx_pkg::*;

   logic [3:0]        idx_q;
   logic [DATA_W-1:0] port_b_q;
   logic [DATA_W-1:0] regs [0:13];
   logic [DATA_W-1:0] port_a;
   logic [JOY_W-1:0]  stick_0;
   logic [JOY_W-1:0]  stick_1;
   logic              wr_en;

   // Active-low stick, reordered as 5,4,0,1,2,3
   // Forced high when disabled, triggers masked by their enables
   function automatic logic [JOY_W-1:0] stick_bits(
      input logic [JOY_W-1:0] joy,
      input logic             off,
      input logic [1:0]       trig_en
   );
      logic [JOY_W-1:0] raw;
      raw = off ? '1 : {~joy[5], ~joy[4], ~joy[0], ~joy[1], ~joy[2], ~joy[3]};
      return raw & {trig_en[0], trig_en[1], 4'hF};
   endfunction

   assign wr_en = bus.req & bus.wr & bus.psg_cs;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         idx_q    <= '0;
         port_b_q <= '0;
      end else if (wr_en) begin
         if (bus.addr == 2'd0) begin
            idx_q <= bus.wdata[3:0];
         end else if (bus.addr == 2'd1 && idx_q == PSG_REG_PORTB) begin
            port_b_q <= bus.wdata;
         end
      end
   end

   // Port A is an input, writes to it are dropped
   always_ff @(posedge clk21m) begin
      if (wr_en && bus.addr == 2'd1 && idx_q < PSG_REG_PORTA) begin
         regs[idx_q] <= bus.wdata;
      end
   end

   assign stick_0 = stick_bits(joy0_i, port_b_q[4], port_b_q[1:0]);
   assign stick_1 = stick_bits(joy1_i, port_b_q[5], port_b_q[3:2]);
   assign port_a  = {cas_audio_i, 1'b0, port_b_q[6] ? stick_1 : stick_0};

   always_comb begin
      rdata_o = 8'hFF;
      if (bus.rd && bus.psg_cs && bus.addr == 2'd2) begin
         if (idx_q == PSG_REG_PORTA) rdata_o = port_a;
         else if (idx_q == PSG_REG_PORTB) rdata_o = port_b_q;
         else rdata_o = regs[idx_q];
      end
   end

endmodule

// File: design/audio_mixer.sv
`timescale 1ns/1ps

module audio_mixer (
   input  logic                                clk21m,
   input  logic                                exwait_n,
   input  logic [msx_pkg::PSG_LEVEL_W-1:0]     psg_level_i,
   input  logic                                keybeep_i,
   input  logic                                cas_audio_i,
   input  logic                                cas_motor_i,
   input  logic signed [msx_pkg::AUDIO_W-1:0]  device_sound_i,
   output logic signed [msx_pkg::AUDIO_W-1:0]  audio_o
);
   import msx_pkg::*;

   logic [AUDIO_W:0]   psg_part;
   logic [AUDIO_W:0]   beep_part;
   logic [AUDIO_W:0]   cas_part;
   logic [AUDIO_W:0]   mix;
   logic [AUDIO_W-1:0] clipped;

   // PSG level scaled by 16
   assign psg_part  = {3'b000, psg_level_i, 4'b0000};
   assign beep_part = keybeep_i ? (AUDIO_W + 1)'(BEEP_WEIGHT * 16) : '0;
   // Cassette is only heard while the motor relay is open
   assign cas_part  = (cas_audio_i && !cas_motor_i) ? (AUDIO_W + 1)'(CAS_WEIGHT * 16) : '0;

   assign mix = {device_sound_i[AUDIO_W-1], device_sound_i} + psg_part + beep_part + cas_part;

   always_comb begin
      case (mix[AUDIO_W:AUDIO_W-2])
         3'b000, 3'b111: clipped = {mix[AUDIO_W], mix[13:0], 1'b0};
         3'b001, 3'b010, 3'b011: clipped = 16'h7FFF;
         default: clipped = 16'h8000;
      endcase
   end

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) audio_o <= '0;
      else audio_o <= clipped;
   end

endmodule

// File: design/msx_io_glue.sv
`timescale 1ns/1ps

module msx_io_glue (
   input  logic                                clk21m,
   input  logic                                exwait_n,
   input  logic                                ce_3m58_p_i,
   input  logic [msx_pkg::ADDR_W-1:0]          addr_i,
   input  logic [msx_pkg::DATA_W-1:0]          data_i,
   input  logic                                iorq_n_i,
   input  logic                                mreq_n_i,
   input  logic                                rd_n_i,
   input  logic                                wr_n_i,
   input  logic                                m1_n_i,
   output logic [msx_pkg::DATA_W-1:0]          data_o,
   output logic                                wait_n_o,
   input  logic [msx_pkg::DATA_W-1:0]          vdp_data_i,
   output logic                                vdp_cs_o,
   input  logic [msx_pkg::DATA_W-1:0]          kb_data_i,
   output logic [3:0]                          kb_row_o,
   output logic                                cas_motor_o,
   output logic [1:0]                          active_slot_o,
   input  logic [msx_pkg::JOY_W-1:0]           joy0_i,
   input  logic [msx_pkg::JOY_W-1:0]           joy1_i,
   input  logic                                cas_audio_i,
   input  logic [msx_pkg::PSG_LEVEL_W-1:0]     psg_level_i,
   input  logic signed [msx_pkg::AUDIO_W-1:0]  device_sound_i,
   output logic signed [msx_pkg::AUDIO_W-1:0]  audio_o
);
   import msx_pkg::*;

   logic [DATA_W-1:0] ppi_rdata;
   logic [DATA_W-1:0] psg_rdata;
   logic              keybeep;

   cpu_bus_if bus ();

   io_select u_io_select (
      .clk21m(clk21m), .exwait_n(exwait_n), .addr_i(addr_i), .data_i(data_i),
      .iorq_n_i(iorq_n_i), .mreq_n_i(mreq_n_i), .rd_n_i(rd_n_i), .wr_n_i(wr_n_i),
      .m1_n_i(m1_n_i), .ppi_rdata_i(ppi_rdata), .psg_rdata_i(psg_rdata),
      .vdp_data_i(vdp_data_i), .vdp_cs_o(vdp_cs_o), .data_o(data_o), .bus(bus)
   );

   wait_gen u_wait_gen (
      .clk21m(clk21m), .exwait_n(exwait_n), .ce_3m58_p_i(ce_3m58_p_i),
      .m1_n_i(m1_n_i), .wait_n_o(wait_n_o)
   );

   ppi_slot_port u_ppi_slot_port (
      .clk21m(clk21m), .exwait_n(exwait_n), .bus(bus), .page_i(addr_i[15:14]),
      .kb_data_i(kb_data_i), .rdata_o(ppi_rdata), .active_slot_o(active_slot_o),
      .kb_row_o(kb_row_o), .cas_motor_o(cas_motor_o), .keybeep_o(keybeep)
   );

   psg_port u_psg_port (
      .clk21m(clk21m), .exwait_n(exwait_n), .bus(bus), .joy0_i(joy0_i),
      .joy1_i(joy1_i), .cas_audio_i(cas_audio_i), .rdata_o(psg_rdata)
   );

   audio_mixer u_audio_mixer (
      .clk21m(clk21m), .exwait_n(exwait_n), .psg_level_i(psg_level_i),
      .keybeep_i(keybeep), .cas_audio_i(cas_audio_i), .cas_motor_i(cas_motor_o),
      .device_sound_i(device_sound_i), .audio_o(audio_o)
   );

endmodule

// File: sim/msx_io_tests.svh
`ifndef MSX_IO_TESTS_SVH
`define MSX_IO_TESTS_SVH

task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
   check_count = check_count + 1;
   if (got !== exp) begin
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
      err_count = err_count + 1;
   end
endtask

task automatic report(input string name, input int errs_before);
   $display("%s finished with %0d errors", name, err_count - errs_before);
endtask

// Z80 I/O write, held for two clocks
task automatic io_write(input logic [7:0] port, input logic [7:0] value);
   @(posedge clk21m);
   #1;
   addr = {8'h00, port};
   wdata = value;
   iorq_n = 1'b0;
   wr_n = 1'b0;
   repeat (2) @(posedge clk21m);
   #1;
   iorq_n = 1'b1;
   wr_n = 1'b1;
endtask

// Z80 I/O read, or interrupt acknowledge when m1 is set
task automatic io_read(input logic [7:0] port, input logic m1, output logic [7:0] value);
   @(posedge clk21m);
   #1;
   addr = {8'h00, port};
   iorq_n = 1'b0;
   rd_n = 1'b0;
   m1_n = ~m1;
   @(negedge clk21m);
   value = rdata;
   read_cs = vdp_cs;
   @(posedge clk21m);
   #1;
   iorq_n = 1'b1;
   rd_n = 1'b1;
   m1_n = 1'b1;
endtask

task automatic set_page(input logic [1:0] page);
   @(posedge clk21m);
   #1;
   addr = {page, 14'h0000};
   @(negedge clk21m);
endtask

// Joystick port as seen through PSG register 14
function automatic logic [7:0] expected_port_a(input logic [7:0] r15, input logic [5:0] j0,
                                                input logic [5:0] j1, input logic cas_in);
   logic [5:0] j;
   logic [5:0] v;
   logic [1:0] trig;
   j = r15[6] ? j1 : j0;
   trig = r15[6] ? r15[3:2] : r15[1:0];
   v = {~j[5], ~j[4], ~j[0], ~j[1], ~j[2], ~j[3]};
   if (r15[6] ? r15[5] : r15[4]) v = 6'h3F;
   v[5] = v[5] & trig[0];
   v[4] = v[4] & trig[1];
   return {cas_in, 1'b0, v};
endfunction

function automatic logic [15:0] expected_audio(input int lvl, input int dev, input logic beep,
                                               input logic cas_in, input logic motor);
   int sum;
   sum = dev + lvl * 16;
   if (beep) sum = sum + 512 * 16;
   if (cas_in && !motor) sum = sum + 256 * 16;
   // Within range the output is twice the sum
   if (sum > 16383) return 16'h7FFF;
   if (sum < -16384) return 16'h8000;
   return 16'(sum * 2);
endfunction

task automatic reset_and_slots();
   int start;
   logic [31:0] r;
   logic [7:0] slots;
   start = err_count;
   check_equal(wait_n, 1, "wait_n after reset");
   check_equal(cas_motor, 0, "cas_motor after reset");
   check_equal(kb_row, 0, "kb_row after reset");
   check_equal(audio, 0, "audio after reset");
   for (int p = 0; p < 4; p++) begin
      set_page(2'(p));
      check_equal(active_slot, 0, $sformatf("slot before PPI access, page %0d", p));
   end
   r = $random(seed);
   slots = r[7:0];
   io_write(8'hA8, slots);
   for (int p = 0; p < 4; p++) begin
      set_page(2'(p));
      check_equal(active_slot, slots[2*p +: 2], $sformatf("slot of page %0d", p));
   end
   report("reset_and_slots", start);
endtask

task automatic ppi_port_c();
   int start;
   logic [31:0] r;
   logic [7:0] exp_c;
   logic [7:0] v;
   start = err_count;
   exp_c = 8'h00;
   for (int i = 0; i < 16; i++) begin
      r = $random(seed);
      io_write(8'hAB, {4'b0000, r[3:1], r[0]});
      exp_c[r[3:1]] = r[0];
      check_equal(kb_row, exp_c[3:0], "kb_row after bit set/reset");
      check_equal(cas_motor, exp_c[4], "cas_motor after bit set/reset");
   end
   // Mode word must leave port C alone
   r = $random(seed);
   io_write(8'hAB, {1'b1, r[6:0]});
   io_read(8'hAA, 1'b0, v);
   check_equal(v, exp_c, "port C after mode write");
   r = $random(seed);
   kb_data = r[7:0];
   io_read(8'hA9, 1'b0, v);
   check_equal(v, kb_data, "keyboard data on port B");
   report("ppi_port_c", start);
endtask

task automatic psg_registers();
   int start;
   logic [31:0] r;
   logic [7:0] shadow [0:13];
   logic [7:0] r15_set [0:5];
   logic [7:0] v;
   start = err_count;
   for (int i = 0; i < 14; i++) begin
      r = $random(seed);
      shadow[i] = r[7:0];
      io_write(8'hA0, 8'(i));
      io_write(8'hA1, shadow[i]);
   end
   for (int i = 0; i < 14; i++) begin
      io_write(8'hA0, 8'(i));
      io_read(8'hA2, 1'b0, v);
      check_equal(v, shadow[i], $sformatf("PSG register %0d", i));
   end
   r15_set = '{8'h00, 8'h0F, 8'h4F, 8'h1F, 8'h6F, 8'h46};
   for (int s = 0; s < 6; s++) begin
      io_write(8'hA0, 8'd15);
      io_write(8'hA1, r15_set[s]);
      io_read(8'hA2, 1'b0, v);
      check_equal(v, r15_set[s], "PSG register 15");
      for (int k = 0; k < 3; k++) begin
         r = $random(seed);
         joy0 = r[5:0];
         joy1 = r[11:6];
         cas_audio = r[12];
         io_write(8'hA0, 8'd14);
         io_read(8'hA2, 1'b0, v);
         check_equal(v, expected_port_a(r15_set[s], joy0, joy1, cas_audio),
                     $sformatf("PSG register 14, r15 %0h", r15_set[s]));
      end
   end
   report("psg_registers", start);
endtask

task automatic port_decode();
   int start;
   logic [31:0] r;
   logic [7:0] v;
   start = err_count;
   io_read(8'h40, 1'b0, v);
   check_equal(v, 8'hFF, "read from unused port");
   io_read(8'hA8, 1'b1, v);
   check_equal(v, 8'hFF, "read during M1");
   for (int p = 8'h98; p <= 8'h9F; p++) begin
      r = $random(seed);
      vdp_data = r[7:0];
      io_read(8'(p), 1'b0, v);
      check_equal(v, vdp_data, $sformatf("VDP read at port %0h", p));
      check_equal(read_cs, 1, $sformatf("vdp_cs at port %0h", p));
   end
   report("port_decode", start);
endtask

task automatic m1_wait();
   int start;
   int low_cycles;
   int falls;
   logic prev;
   start = err_count;
   for (int n = 0; n < 3; n++) begin
      low_cycles = 0;
      falls = 0;
      prev = 1'b1;
      @(posedge clk21m);
      #1;
      m1_n = 1'b0;
      mreq_n = 1'b0;
      rd_n = 1'b0;
      for (int k = 0; k < 30; k++) begin
         @(negedge clk21m);
         if (!wait_n) low_cycles++;
         if (prev && !wait_n) falls++;
         prev = wait_n;
         if (k == 14) begin
            @(posedge clk21m);
            #1;
            m1_n = 1'b1;
            mreq_n = 1'b1;
            rd_n = 1'b1;
         end
      end
      check_equal(falls, 1, "wait pulses per M1 cycle");
      check_equal(low_cycles, 6, "wait length in clk21m cycles");
   end
   report("m1_wait", start);
endtask

task automatic mix_case(input int lvl, input int dev, input logic beep, input logic cas_in,
                        input logic motor);
   logic [15:0] exp;
   io_write(8'hAB, {4'b0000, 3'd7, beep});
   io_write(8'hAB, {4'b0000, 3'd4, motor});
   exp = expected_audio(lvl, dev, beep, cas_in, motor);
   @(posedge clk21m);
   #1;
   psg_level = 10'(lvl);
   device_sound = 16'(dev);
   cas_audio = cas_in;
   @(posedge clk21m);
   @(negedge clk21m);
   check_equal({16'h0, audio}, {16'h0, exp}, $sformatf("audio lvl %0d dev %0d", lvl, dev));
endtask

task automatic audio_mixing();
   int start;
   logic [31:0] r;
   logic [31:0] f;
   start = err_count;
   mix_case(1023, 32767, 1'b1, 1'b1, 1'b0);
   mix_case(0, -32768, 1'b0, 1'b0, 1'b0);
   mix_case(0, 16383, 1'b0, 1'b0, 1'b1);
   mix_case(0, -16385, 1'b0, 1'b1, 1'b1);
   mix_case(100, -20000, 1'b1, 1'b0, 1'b0);
   for (int i = 0; i < 8; i++) begin
      r = $random(seed);
      f = $random(seed);
      mix_case(int'(r[9:0]), int'($signed(r[31:16])), f[0], f[1], f[2]);
   end
   report("audio_mixing", start);
endtask

`endif

// File: sim/tb_msx_io_glue.sv
`timescale 1ns/1ps

module tb_msx_io_glue;

   // The directed tests need roughly 1500 cycles
   localparam int TIMEOUT_CYCLES = 4000;

   logic         clk21m;
   logic         exwait_n;
   logic         ce_3m58_p;
   logic [15:0]  addr;
   logic [7:0]   wdata;
   logic         iorq_n;
   logic         mreq_n;
   logic         rd_n;
   logic         wr_n;
   logic         m1_n;
   logic [7:0]   rdata;
   logic         wait_n;
   logic [7:0]   vdp_data;
   logic         vdp_cs;
   logic [7:0]   kb_data;
   logic [3:0]   kb_row;
   logic         cas_motor;
   logic [1:0]   active_slot;
   logic [5:0]   joy0;
   logic [5:0]   joy1;
   logic         cas_audio;
   logic [9:0]   psg_level;
   logic signed [15:0] device_sound;
   logic signed [15:0] audio;

   integer seed;
   int     err_count;
   int     check_count;
   int     cycle_count;
   int     ce_count;
   logic   read_cs;

   msx_io_glue u_msx_io_glue (
      .clk21m(clk21m), .exwait_n(exwait_n), .ce_3m58_p_i(ce_3m58_p),
      .addr_i(addr), .data_i(wdata), .iorq_n_i(iorq_n), .mreq_n_i(mreq_n),
      .rd_n_i(rd_n), .wr_n_i(wr_n), .m1_n_i(m1_n), .data_o(rdata),
      .wait_n_o(wait_n), .vdp_data_i(vdp_data), .vdp_cs_o(vdp_cs),
      .kb_data_i(kb_data), .kb_row_o(kb_row), .cas_motor_o(cas_motor),
      .active_slot_o(active_slot), .joy0_i(joy0), .joy1_i(joy1),
      .cas_audio_i(cas_audio), .psg_level_i(psg_level),
      .device_sound_i(device_sound), .audio_o(audio)
   );

   always #5 clk21m = ~clk21m;

   // CPU clock enable high for one cycle in six
   always @(posedge clk21m) begin
      #1;
      if (ce_count == 5) begin
         ce_count = 0;
         ce_3m58_p = 1'b1;
      end else begin
         ce_count = ce_count + 1;
         ce_3m58_p = 1'b0;
      end
   end

   always @(posedge clk21m) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   `include "msx_io_tests.svh"

   initial begin
      seed = 32'hd771;
      err_count = 0;
      check_count = 0;
      cycle_count = 0;
      ce_count = 0;
      read_cs = 1'b0;
      clk21m = 1'b0;
      exwait_n = 1'b0;
      ce_3m58_p = 1'b0;
      addr = '0;
      wdata = '0;
      iorq_n = 1'b1;
      mreq_n = 1'b1;
      rd_n = 1'b1;
      wr_n = 1'b1;
      m1_n = 1'b1;
      vdp_data = '0;
      kb_data = '0;
      joy0 = '0;
      joy1 = '0;
      cas_audio = 1'b0;
      psg_level = '0;
      // Nonzero sound so only reset keeps the audio output at zero
      device_sound = 16'sh0400;
      repeat (4) @(posedge clk21m);
      #1;
      exwait_n = 1'b1;

      reset_and_slots();
      ppi_port_c();
      psg_registers();
      port_decode();
      m1_wait();
      audio_mixing();

      $display("Checks: %0d, errors: %0d", check_count, err_count);
      if (err_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: msx_io_glue.f
+incdir+sim
common/msx_pkg.sv
common/cpu_bus_if.sv
design/io_select.sv
design/wait_gen.sv
design/ppi/ppi_slot_port.sv
design/psg/psg_port.sv
design/audio_mixer.sv
design/msx_io_glue.sv
sim/tb_msx_io_glue.sv

// File: Makefile
TOP = tb_msx_io_glue

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f msx_io_glue.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
